// ==== include/tdu_defines.svh ====
// Trigger debug unit constants, included by the package and the RTL that decodes CSR fields
`ifndef TDU_DEFINES_SVH
`define TDU_DEFINES_SVH

// ------------------------------
// Widths and trigger count
// ------------------------------

`define TDU_DATA_W          32      // CSR word and address width
`define TDU_MTRIG_NUM       4       // Address-match triggers
`define TDU_TSEL_W          2       // Enough to index every trigger
`define TDU_CSR_ADDR_W      3

// ------------------------------
// CSR offsets within the TDU block
// ------------------------------

`define TDU_OFFS_TSELECT    3'd0
`define TDU_OFFS_TDATA1     3'd1
`define TDU_OFFS_TDATA2     3'd2
`define TDU_OFFS_TINFO      3'd4

// ------------------------------
// tdata1 fields common to all types
// ------------------------------

`define TDU_TDATA1_TYPE_HI  31
`define TDU_TDATA1_TYPE_LO  28
`define TDU_TDATA1_DMODE    27

// ------------------------------
// mcontrol fields
// ------------------------------

`define TDU_MC_HIT          20
`define TDU_MC_ACTION_HI    17
`define TDU_MC_ACTION_LO    12
`define TDU_MC_M            6
`define TDU_MC_EXECUTE      2
`define TDU_MC_STORE        1
`define TDU_MC_LOAD         0

// Type code of an address-match trigger, also its bit in tinfo
`define TDU_MC_TYPE_VAL     2

`endif

// ==== hdl/tdu_pkg.sv ====
// Shared types of the trigger debug unit, imported by every module of the unit
`default_nettype none

`include "tdu_defines.svh"

package tdu_pkg;

    typedef logic [`TDU_DATA_W-1:0]     tdu_data_t;      // CSR word or address
    typedef logic [`TDU_CSR_ADDR_W-1:0] tdu_csr_addr_t;  // Offset inside the TDU block
    typedef logic [`TDU_TSEL_W-1:0]     tdu_tsel_t;      // Trigger index
    typedef logic [`TDU_MTRIG_NUM-1:0]  tdu_trig_vec_t;  // One bit per trigger

    // CSR command from the core
    typedef enum logic [1:0] {
        TDU_CMD_NONE  = 2'd0,
        TDU_CMD_WRITE = 2'd1,
        TDU_CMD_SET   = 2'd2,
        TDU_CMD_CLEAR = 2'd3
    } tdu_csr_cmd_e;

    // CSR response back to the core
    typedef enum logic {
        TDU_RESP_OK = 1'b0,
        TDU_RESP_ER = 1'b1
    } tdu_csr_resp_e;

endpackage

`default_nettype wire

// ==== hdl/tdu_csr_if.sv ====
// CSR access port of the trigger unit; decodes offsets, forms write data and holds tselect
`timescale 1ns/10ps
`default_nettype none

`include "tdu_defines.svh"

module tdu_csr_if (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    csr_req_i,
    input  tdu_pkg::tdu_csr_cmd_e   csr_cmd_i,
    input  tdu_pkg::tdu_csr_addr_t  csr_addr_i,
    input  tdu_pkg::tdu_data_t      csr_wdata_i,
    input  tdu_pkg::tdu_data_t      sel_tdata1_i,   // tdata1 of the selected trigger
    input  tdu_pkg::tdu_data_t      sel_tdata2_i,   // tdata2 of the selected trigger
    output tdu_pkg::tdu_data_t      csr_rdata_o,
    output tdu_pkg::tdu_csr_resp_e  csr_resp_o,
    output tdu_pkg::tdu_tsel_t      tsel_o,
    output logic                    tdata1_wr_o,
    output logic                    tdata2_wr_o,
    output tdu_pkg::tdu_data_t      wr_data_o
);

    import tdu_pkg::*;

    tdu_tsel_t  tsel_q;
    tdu_data_t  rdata;
    tdu_data_t  wr_data;
    logic       wr_req;
    logic       tsel_wr;

    // ------------------------------
    // Read path
    // ------------------------------

    assign csr_resp_o = csr_req_i ? TDU_RESP_OK : TDU_RESP_ER;

    always_comb begin
        rdata = '0;
        if (csr_req_i) begin
            case (csr_addr_i)
                `TDU_OFFS_TSELECT: rdata = tdu_data_t'(tsel_q);
                `TDU_OFFS_TDATA1:  rdata = sel_tdata1_i;
                `TDU_OFFS_TDATA2:  rdata = sel_tdata2_i;
                `TDU_OFFS_TINFO:   rdata[`TDU_MC_TYPE_VAL] = 1'b1;  // Only mcontrol supported
                default:           rdata = '0;
            endcase
        end
    end

    assign csr_rdata_o = rdata;

    // ------------------------------
    // Write path
    // ------------------------------

    // Set and clear merge into the current read value
    always_comb begin
        wr_req  = 1'b0;
        wr_data = '0;
        case (csr_cmd_i)
            TDU_CMD_WRITE: begin
                wr_req  = 1'b1;
                wr_data = csr_wdata_i;
            end
            TDU_CMD_SET: begin
                wr_req  = |csr_wdata_i;  // Zero mask leaves the register alone
                wr_data = rdata | csr_wdata_i;
            end
            TDU_CMD_CLEAR: begin
                wr_req  = |csr_wdata_i;
                wr_data = rdata & ~csr_wdata_i;
            end
            default: begin
                wr_req  = 1'b0;
                wr_data = '0;
            end
        endcase
    end

    // One strobe per addressed register
    assign tsel_wr     = csr_req_i & wr_req & (csr_addr_i == `TDU_OFFS_TSELECT);
    assign tdata1_wr_o = csr_req_i & wr_req & (csr_addr_i == `TDU_OFFS_TDATA1);
    assign tdata2_wr_o = csr_req_i & wr_req & (csr_addr_i == `TDU_OFFS_TDATA2);
    assign wr_data_o   = wr_data;

    // tselect covers exactly the trigger count, so every written index is in range
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tsel_q <= '0;
        end else if (tsel_wr) begin
            tsel_q <= wr_data[`TDU_TSEL_W-1:0];
        end
    end

    assign tsel_o = tsel_q;

endmodule

`default_nettype wire

// ==== hdl/tdu_mcontrol_trig.sv ====
// One address-match trigger; holds its mcontrol fields and tdata2 and raises exec and load/store hits
`timescale 1ns/10ps
`default_nettype none

`include "tdu_defines.svh"

module tdu_mcontrol_trig (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tdu_dsbl_i,     // High in debug mode
    input  logic                tdata1_wr_i,
    input  logic                tdata2_wr_i,
    input  tdu_pkg::tdu_data_t  wr_data_i,
    input  logic                bp_retire_i,    // This trigger's breakpoint retires
    input  logic                imon_vd_i,
    input  tdu_pkg::tdu_data_t  imon_addr_i,
    input  logic                dmon_vd_i,
    input  logic                dmon_load_i,
    input  logic                dmon_store_i,
    input  tdu_pkg::tdu_data_t  dmon_addr_i,
    output tdu_pkg::tdu_data_t  tdata1_o,
    output tdu_pkg::tdu_data_t  tdata2_o,
    output logic                exec_hit_o,
    output logic                ldst_hit_o,
    output logic                action_o
);

    import tdu_pkg::*;

    logic       dmode_q;
    logic       m_q;
    logic       exec_q;
    logic       load_q;
    logic       store_q;
    logic       action_q;   // Debug-mode entry instead of exception
    logic       hit_q;
    tdu_data_t  tdata2_q;

    logic       tdata1_upd;
    logic       tdata2_upd;
    logic       armed;

    // Debug-mode owned triggers only change from inside debug mode
    assign tdata1_upd = tdata1_wr_i & (~dmode_q | tdu_dsbl_i);
    assign tdata2_upd = tdata2_wr_i & (~dmode_q | tdu_dsbl_i);

    // ------------------------------
    // Control fields
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmode_q  <= 1'b0;
            m_q      <= 1'b0;
            exec_q   <= 1'b0;
            load_q   <= 1'b0;
            store_q  <= 1'b0;
            action_q <= 1'b0;
            hit_q    <= 1'b0;
        end else begin
            if (tdata1_upd) begin
                dmode_q  <= wr_data_i[`TDU_TDATA1_DMODE];
                m_q      <= wr_data_i[`TDU_MC_M];
                exec_q   <= wr_data_i[`TDU_MC_EXECUTE];
                load_q   <= wr_data_i[`TDU_MC_LOAD];
                store_q  <= wr_data_i[`TDU_MC_STORE];
                action_q <= (wr_data_i[`TDU_MC_ACTION_HI:`TDU_MC_ACTION_LO] == 1);
                hit_q    <= wr_data_i[`TDU_MC_HIT];    // Software write wins over retire
            end else if (bp_retire_i) begin
                hit_q    <= 1'b1;   // Sticky until software clears it
            end
        end
    end

    // Match address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tdata2_q <= '0;
        end else if (tdata2_upd) begin
            tdata2_q <= wr_data_i;
        end
    end

    // ------------------------------
    // Readback and match
    // ------------------------------

    always_comb begin
        tdata1_o = tdu_data_t'(`TDU_MC_TYPE_VAL) << `TDU_TDATA1_TYPE_LO;
        tdata1_o[`TDU_TDATA1_DMODE] = dmode_q;
        tdata1_o[`TDU_MC_HIT]       = hit_q;
        tdata1_o[`TDU_MC_ACTION_LO] = action_q;   // Upper action bits read 0
        tdata1_o[`TDU_MC_M]         = m_q;
        tdata1_o[`TDU_MC_EXECUTE]   = exec_q;
        tdata1_o[`TDU_MC_STORE]     = store_q;
        tdata1_o[`TDU_MC_LOAD]      = load_q;
    end

    assign tdata2_o = tdata2_q;
    assign action_o = action_q;

    assign armed = ~tdu_dsbl_i & m_q;

    assign exec_hit_o = armed & exec_q & imon_vd_i & (imon_addr_i == tdata2_q);

    assign ldst_hit_o = armed & dmon_vd_i
                      & ((load_q & dmon_load_i) | (store_q & dmon_store_i))
                      & (dmon_addr_i == tdata2_q);

endmodule

`default_nettype wire

// ==== hdl/tdu_trig_bank.sv ====
// Array of address-match triggers with tselect write steering, readback and request reduction
`timescale 1ns/10ps
`default_nettype none

`include "tdu_defines.svh"

module tdu_trig_bank (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tdu_dsbl_i,
    input  tdu_pkg::tdu_tsel_t      tsel_i,
    input  logic                    tdata1_wr_i,
    input  logic                    tdata2_wr_i,
    input  tdu_pkg::tdu_data_t      wr_data_i,
    input  tdu_pkg::tdu_trig_vec_t  bp_retire_i,
    input  logic                    imon_vd_i,
    input  tdu_pkg::tdu_data_t      imon_addr_i,
    input  logic                    dmon_vd_i,
    input  logic                    dmon_load_i,
    input  logic                    dmon_store_i,
    input  tdu_pkg::tdu_data_t      dmon_addr_i,
    output tdu_pkg::tdu_data_t      sel_tdata1_o,
    output tdu_pkg::tdu_data_t      sel_tdata2_o,
    output tdu_pkg::tdu_trig_vec_t  ibrkpt_match_o,
    output logic                    ibrkpt_exc_req_o,
    output tdu_pkg::tdu_trig_vec_t  dbrkpt_match_o,
    output logic                    dbrkpt_exc_req_o,
    output logic                    dmode_req_o
);

    import tdu_pkg::*;

    tdu_data_t      tdata1_arr [`TDU_MTRIG_NUM];
    tdu_data_t      tdata2_arr [`TDU_MTRIG_NUM];
    tdu_trig_vec_t  tdata1_wr;
    tdu_trig_vec_t  tdata2_wr;
    tdu_trig_vec_t  exec_hit;
    tdu_trig_vec_t  ldst_hit;
    tdu_trig_vec_t  action;

    // ------------------------------
    // Trigger array
    // ------------------------------

    for (genvar i = 0; i < `TDU_MTRIG_NUM; i++) begin : gen_trig
        // Only the selected trigger sees the strobe
        assign tdata1_wr[i] = tdata1_wr_i & (tsel_i == tdu_tsel_t'(i));
        assign tdata2_wr[i] = tdata2_wr_i & (tsel_i == tdu_tsel_t'(i));

        tdu_mcontrol_trig trig_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .tdu_dsbl_i   (tdu_dsbl_i),
            .tdata1_wr_i  (tdata1_wr[i]),
            .tdata2_wr_i  (tdata2_wr[i]),
            .wr_data_i    (wr_data_i),
            .bp_retire_i  (bp_retire_i[i]),
            .imon_vd_i    (imon_vd_i),
            .imon_addr_i  (imon_addr_i),
            .dmon_vd_i    (dmon_vd_i),
            .dmon_load_i  (dmon_load_i),
            .dmon_store_i (dmon_store_i),
            .dmon_addr_i  (dmon_addr_i),
            .tdata1_o     (tdata1_arr[i]),
            .tdata2_o     (tdata2_arr[i]),
            .exec_hit_o   (exec_hit[i]),
            .ldst_hit_o   (ldst_hit[i]),
            .action_o     (action[i])
        );
    end

    // Selected trigger readback
    assign sel_tdata1_o = tdata1_arr[tsel_i];
    assign sel_tdata2_o = tdata2_arr[tsel_i];

    // ------------------------------
    // Requests toward the core
    // ------------------------------

    assign ibrkpt_match_o   = exec_hit;
    assign ibrkpt_exc_req_o = |exec_hit;
    assign dbrkpt_match_o   = ldst_hit;
    assign dbrkpt_exc_req_o = |ldst_hit;

    assign dmode_req_o = |(action & bp_retire_i);   // Retiring trigger with action 1

endmodule

`default_nettype wire

// ==== hdl/tdu_top.sv ====
// Top level of the trigger debug unit; wires the CSR port to the trigger bank
`timescale 1ns/10ps
`default_nettype none

module tdu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // CSR port
    input  logic                    csr_req_i,
    input  tdu_pkg::tdu_csr_cmd_e   csr_cmd_i,
    input  tdu_pkg::tdu_csr_addr_t  csr_addr_i,
    input  tdu_pkg::tdu_data_t      csr_wdata_i,
    output tdu_pkg::tdu_data_t      csr_rdata_o,
    output tdu_pkg::tdu_csr_resp_e  csr_resp_o,
    input  logic                    tdu_dsbl_i,     // Core is in debug mode
    // Instruction and data monitors
    input  logic                    imon_vd_i,
    input  tdu_pkg::tdu_data_t      imon_addr_i,
    input  logic                    dmon_vd_i,
    input  logic                    dmon_load_i,
    input  logic                    dmon_store_i,
    input  tdu_pkg::tdu_data_t      dmon_addr_i,
    input  tdu_pkg::tdu_trig_vec_t  bp_retire_i,
    // Requests
    output tdu_pkg::tdu_trig_vec_t  ibrkpt_match_o,
    output tdu_pkg::tdu_trig_vec_t  dbrkpt_match_o,
    output logic                    ibrkpt_exc_req_o,
    output logic                    dbrkpt_exc_req_o,
    output logic                    dmode_req_o
);

    import tdu_pkg::*;

    tdu_tsel_t  tsel;
    logic       tdata1_wr;
    logic       tdata2_wr;
    tdu_data_t  wr_data;
    tdu_data_t  sel_tdata1;
    tdu_data_t  sel_tdata2;

    tdu_csr_if csr_if_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_req_i    (csr_req_i),
        .csr_cmd_i    (csr_cmd_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .sel_tdata1_i (sel_tdata1),
        .sel_tdata2_i (sel_tdata2),
        .csr_rdata_o  (csr_rdata_o),
        .csr_resp_o   (csr_resp_o),
        .tsel_o       (tsel),
        .tdata1_wr_o  (tdata1_wr),
        .tdata2_wr_o  (tdata2_wr),
        .wr_data_o    (wr_data)
    );

    tdu_trig_bank trig_bank_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .tdu_dsbl_i       (tdu_dsbl_i),
        .tsel_i           (tsel),
        .tdata1_wr_i      (tdata1_wr),
        .tdata2_wr_i      (tdata2_wr),
        .wr_data_i        (wr_data),
        .bp_retire_i      (bp_retire_i),
        .imon_vd_i        (imon_vd_i),
        .imon_addr_i      (imon_addr_i),
        .dmon_vd_i        (dmon_vd_i),
        .dmon_load_i      (dmon_load_i),
        .dmon_store_i     (dmon_store_i),
        .dmon_addr_i      (dmon_addr_i),
        .sel_tdata1_o     (sel_tdata1),
        .sel_tdata2_o     (sel_tdata2),
        .ibrkpt_match_o   (ibrkpt_match_o),
        .ibrkpt_exc_req_o (ibrkpt_exc_req_o),
        .dbrkpt_match_o   (dbrkpt_match_o),
        .dbrkpt_exc_req_o (dbrkpt_exc_req_o),
        .dmode_req_o      (dmode_req_o)
    );

endmodule

`default_nettype wire

// ==== sim/tdu_asserts.sv ====
// Concurrent checks on the trigger unit's CSR response and requests, bound into tdu_top
`timescale 1ns/10ps
`default_nettype none

module tdu_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     csr_req_i,
    input tdu_pkg::tdu_csr_resp_e   csr_resp_o,
    input logic                     tdu_dsbl_i,
    input tdu_pkg::tdu_trig_vec_t   ibrkpt_match_o,
    input tdu_pkg::tdu_trig_vec_t   dbrkpt_match_o,
    input logic                     ibrkpt_exc_req_o,
    input logic                     dbrkpt_exc_req_o
);

    import tdu_pkg::*;

    int assert_errors = 0;  // Read by the testbench at the end of the run

    // Response follows the request level
    resp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        csr_resp_o == (csr_req_i ? TDU_RESP_OK : TDU_RESP_ER))
        else begin
            assert_errors++;
            $error("csr_resp_o does not follow csr_req_i");
        end

    ibrkpt_req_is_or: assert property (@(posedge clk) disable iff (!rst_n)
        ibrkpt_exc_req_o == (|ibrkpt_match_o))
        else begin
            assert_errors++;
            $error("ibrkpt_exc_req_o differs from the OR of ibrkpt_match_o");
        end

    dbrkpt_req_is_or: assert property (@(posedge clk) disable iff (!rst_n)
        dbrkpt_exc_req_o == (|dbrkpt_match_o))
        else begin
            assert_errors++;
            $error("dbrkpt_exc_req_o differs from the OR of dbrkpt_match_o");
        end

    // Debug mode masks every hit
    quiet_in_debug: assert property (@(posedge clk) disable iff (!rst_n)
        tdu_dsbl_i |-> !(ibrkpt_exc_req_o || dbrkpt_exc_req_o
                         || (|ibrkpt_match_o) || (|dbrkpt_match_o)))
        else begin
            assert_errors++;
            $error("Breakpoint request raised while tdu_dsbl_i is high");
        end

endmodule

bind tdu_top tdu_asserts asserts_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .csr_req_i        (csr_req_i),
    .csr_resp_o       (csr_resp_o),
    .tdu_dsbl_i       (tdu_dsbl_i),
    .ibrkpt_match_o   (ibrkpt_match_o),
    .dbrkpt_match_o   (dbrkpt_match_o),
    .ibrkpt_exc_req_o (ibrkpt_exc_req_o),
    .dbrkpt_exc_req_o (dbrkpt_exc_req_o)
);

`default_nettype wire

// ==== sim/tdu_tb.sv ====
// Directed testbench for the trigger debug unit; compile with the file list and run tdu_tb as top
`timescale 1ns/10ps
`default_nettype none

`include "tdu_defines.svh"

module tdu_tb;

    import tdu_pkg::*;

    localparam int        TIMEOUT_CYCLES = 400;             // About three times the test length
    localparam tdu_data_t TYPE_WORD      = 32'h2000_0000;   // Type 2, all fields clear
    localparam tdu_data_t DMODE_BIT      = 32'h1 << `TDU_TDATA1_DMODE;
    localparam tdu_data_t HIT_BIT        = 32'h1 << `TDU_MC_HIT;
    localparam tdu_data_t ACTION_ONE     = 32'h1 << `TDU_MC_ACTION_LO;
    localparam tdu_data_t M_BIT          = 32'h1 << `TDU_MC_M;
    localparam tdu_data_t EXEC_BIT       = 32'h1 << `TDU_MC_EXECUTE;
    localparam tdu_data_t STORE_BIT      = 32'h1 << `TDU_MC_STORE;
    localparam tdu_data_t LOAD_BIT       = 32'h1 << `TDU_MC_LOAD;

    logic           clk;
    logic           rst_n;
    logic           csr_req;
    tdu_csr_cmd_e   csr_cmd;
    tdu_csr_addr_t  csr_addr;
    tdu_data_t      csr_wdata;
    tdu_data_t      csr_rdata;
    tdu_csr_resp_e  csr_resp;
    logic           tdu_dsbl;
    logic           imon_vd;
    tdu_data_t      imon_addr;
    logic           dmon_vd;
    logic           dmon_load;
    logic           dmon_store;
    tdu_data_t      dmon_addr;
    tdu_trig_vec_t  bp_retire;
    tdu_trig_vec_t  ibrkpt_match;
    tdu_trig_vec_t  dbrkpt_match;
    logic           ibrkpt_exc_req;
    logic           dbrkpt_exc_req;
    logic           dmode_req;

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     assert_fails;
    integer seed = 96589;

    tdu_top tdu_top_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .csr_req_i        (csr_req),
        .csr_cmd_i        (csr_cmd),
        .csr_addr_i       (csr_addr),
        .csr_wdata_i      (csr_wdata),
        .csr_rdata_o      (csr_rdata),
        .csr_resp_o       (csr_resp),
        .tdu_dsbl_i       (tdu_dsbl),
        .imon_vd_i        (imon_vd),
        .imon_addr_i      (imon_addr),
        .dmon_vd_i        (dmon_vd),
        .dmon_load_i      (dmon_load),
        .dmon_store_i     (dmon_store),
        .dmon_addr_i      (dmon_addr),
        .bp_retire_i      (bp_retire),
        .ibrkpt_match_o   (ibrkpt_match),
        .dbrkpt_match_o   (dbrkpt_match),
        .ibrkpt_exc_req_o (ibrkpt_exc_req),
        .dbrkpt_exc_req_o (dbrkpt_exc_req),
        .dmode_req_o      (dmode_req)
    );

    always #10 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_data(input string name, input tdu_data_t act, input tdu_data_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_vec(input string name, input tdu_trig_vec_t act,
                             input tdu_trig_vec_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, act, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, act, exp);
        end
    endtask

    task automatic check_resp(input string name, input tdu_csr_resp_e act,
                              input tdu_csr_resp_e exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, act, exp);
        end
    endtask

    // Match vectors and the exception requests that follow from them
    task automatic check_matches(input tdu_trig_vec_t exp_i, input tdu_trig_vec_t exp_d);
        check_vec("ibrkpt_match_o", ibrkpt_match, exp_i);
        check_bit("ibrkpt_exc_req_o", ibrkpt_exc_req, exp_i != '0);
        check_vec("dbrkpt_match_o", dbrkpt_match, exp_d);
        check_bit("dbrkpt_exc_req_o", dbrkpt_exc_req, exp_d != '0);
    endtask

    // ------------------------------
    // Drivers
    // ------------------------------

    // Request held for one edge, response sampled mid cycle
    task automatic csr_access(input tdu_csr_cmd_e cmd, input tdu_csr_addr_t addr,
                              input tdu_data_t wdata, output tdu_data_t rdata);
        @(posedge clk);
        #2;
        csr_req   = 1'b1;
        csr_cmd   = cmd;
        csr_addr  = addr;
        csr_wdata = wdata;
        @(negedge clk);
        check_resp("csr_resp_o", csr_resp, TDU_RESP_OK);
        rdata = csr_rdata;
        @(posedge clk);     // Write lands here
        #2;
        csr_req   = 1'b0;
        csr_cmd   = TDU_CMD_NONE;
        csr_wdata = '0;
    endtask

    task automatic csr_write(input tdu_csr_addr_t addr, input tdu_data_t wdata);
        tdu_data_t old_value;
        csr_access(TDU_CMD_WRITE, addr, wdata, old_value);
    endtask

    task automatic csr_expect(input string name, input tdu_csr_addr_t addr,
                              input tdu_data_t exp);
        tdu_data_t rdata;
        csr_access(TDU_CMD_NONE, addr, '0, rdata);
        check_data(name, rdata, exp);
    endtask

    task automatic imon_drive(input logic vd, input tdu_data_t addr);
        @(posedge clk);
        #2;
        imon_vd   = vd;
        imon_addr = addr;
        @(negedge clk);
    endtask

    task automatic dmon_drive(input logic vd, input logic load, input logic store,
                              input tdu_data_t addr);
        @(posedge clk);
        #2;
        dmon_vd    = vd;
        dmon_load  = load;
        dmon_store = store;
        dmon_addr  = addr;
        @(negedge clk);
    endtask

    task automatic retire_drive(input tdu_trig_vec_t vec);
        @(posedge clk);
        #2;
        bp_retire = vec;
        @(negedge clk);
    endtask

    task automatic set_dsbl(input logic value);
        @(posedge clk);
        #2;
        tdu_dsbl = value;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic reset_values();
        int t;
        @(negedge clk);
        check_matches(4'b0000, 4'b0000);
        check_bit("dmode_req_o", dmode_req, 1'b0);
        // Address without a request
        @(posedge clk);
        #2;
        csr_addr = `TDU_OFFS_TDATA1;
        @(negedge clk);
        check_resp("csr_resp_o", csr_resp, TDU_RESP_ER);
        check_data("csr_rdata_o", csr_rdata, '0);
        for (t = 0; t < `TDU_MTRIG_NUM; t++) begin
            csr_write(`TDU_OFFS_TSELECT, tdu_data_t'(t));
            csr_expect("tselect", `TDU_OFFS_TSELECT, tdu_data_t'(t));
            csr_expect("tdata1", `TDU_OFFS_TDATA1, TYPE_WORD);
            csr_expect("tdata2", `TDU_OFFS_TDATA2, '0);
        end
        csr_expect("tinfo", `TDU_OFFS_TINFO, 32'h4);
    endtask

    task automatic set_clear_merge();
        tdu_data_t addr;
        tdu_data_t old_value;
        addr = $random(seed) & ~32'h1;
        csr_write(`TDU_OFFS_TSELECT, 32'd1);
        csr_write(`TDU_OFFS_TDATA2, addr);
        csr_expect("tdata2", `TDU_OFFS_TDATA2, addr);
        csr_access(TDU_CMD_SET, `TDU_OFFS_TDATA2, 32'h1, old_value);
        csr_expect("tdata2 after set", `TDU_OFFS_TDATA2, addr | 32'h1);
        csr_access(TDU_CMD_SET, `TDU_OFFS_TDATA1, M_BIT | EXEC_BIT | LOAD_BIT, old_value);
        check_data("tdata1 before set", old_value, TYPE_WORD);
        csr_expect("tdata1 after set", `TDU_OFFS_TDATA1, TYPE_WORD | M_BIT | EXEC_BIT | LOAD_BIT);
        csr_access(TDU_CMD_CLEAR, `TDU_OFFS_TDATA1, EXEC_BIT, old_value);
        csr_expect("tdata1 after clear", `TDU_OFFS_TDATA1, TYPE_WORD | M_BIT | LOAD_BIT);
        // Empty set on the same edge as a retire; only the retire may touch tdata1
        @(posedge clk);
        #2;
        csr_req   = 1'b1;
        csr_cmd   = TDU_CMD_SET;
        csr_addr  = `TDU_OFFS_TDATA1;
        csr_wdata = '0;
        bp_retire = 4'b0010;
        @(posedge clk);
        #2;
        csr_req   = 1'b0;
        csr_cmd   = TDU_CMD_NONE;
        bp_retire = '0;
        csr_expect("tdata1 after empty set", `TDU_OFFS_TDATA1,
                   TYPE_WORD | HIT_BIT | M_BIT | LOAD_BIT);
        csr_access(TDU_CMD_CLEAR, `TDU_OFFS_TDATA1, '1, old_value);
        csr_expect("tdata1 after full clear", `TDU_OFFS_TDATA1, TYPE_WORD);
    endtask

    task automatic exec_match();
        tdu_data_t addr;
        addr = $random(seed) & ~32'h3;
        csr_write(`TDU_OFFS_TSELECT, 32'd2);
        csr_write(`TDU_OFFS_TDATA2, addr);
        csr_write(`TDU_OFFS_TDATA1, M_BIT | EXEC_BIT);
        imon_drive(1'b1, addr);
        check_matches(4'b0100, 4'b0000);
        imon_drive(1'b1, addr ^ 32'h4);
        check_matches(4'b0000, 4'b0000);
        imon_drive(1'b0, addr);
        check_matches(4'b0000, 4'b0000);
        set_dsbl(1'b1);
        imon_drive(1'b1, addr);
        check_matches(4'b0000, 4'b0000);    // Debug mode masks the hit
        imon_drive(1'b0, '0);
        set_dsbl(1'b0);
    endtask

    task automatic load_only_match();
        tdu_data_t addr;
        addr = $random(seed) & ~32'h3;
        csr_write(`TDU_OFFS_TSELECT, 32'd1);
        csr_write(`TDU_OFFS_TDATA2, addr);
        csr_write(`TDU_OFFS_TDATA1, M_BIT | LOAD_BIT);
        dmon_drive(1'b1, 1'b1, 1'b0, addr);
        check_matches(4'b0000, 4'b0010);
        dmon_drive(1'b1, 1'b0, 1'b1, addr);
        check_matches(4'b0000, 4'b0000);
        dmon_drive(1'b1, 1'b1, 1'b0, addr ^ 32'h10);
        check_matches(4'b0000, 4'b0000);
        dmon_drive(1'b0, 1'b1, 1'b0, addr);
        check_matches(4'b0000, 4'b0000);
        dmon_drive(1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic retire_debug_entry();
        csr_write(`TDU_OFFS_TSELECT, 32'd0);
        csr_write(`TDU_OFFS_TDATA1, M_BIT | ACTION_ONE);
        csr_expect("tdata1", `TDU_OFFS_TDATA1, TYPE_WORD | M_BIT | ACTION_ONE);
        retire_drive(4'b0001);
        check_bit("dmode_req_o", dmode_req, 1'b1);
        retire_drive(4'b0000);
        check_bit("dmode_req_o", dmode_req, 1'b0);
        csr_expect("tdata1 hit", `TDU_OFFS_TDATA1, TYPE_WORD | HIT_BIT | M_BIT | ACTION_ONE);
        // Trigger 1 has action 0
        retire_drive(4'b0010);
        check_bit("dmode_req_o", dmode_req, 1'b0);
        retire_drive(4'b0000);
        csr_write(`TDU_OFFS_TSELECT, 32'd1);
        csr_expect("tdata1 hit", `TDU_OFFS_TDATA1, TYPE_WORD | HIT_BIT | M_BIT | LOAD_BIT);
    endtask

    task automatic dmode_write_lock();
        tdu_data_t addr;
        addr = $random(seed);
        csr_write(`TDU_OFFS_TSELECT, 32'd3);
        csr_write(`TDU_OFFS_TDATA1, DMODE_BIT | M_BIT);
        csr_expect("tdata1", `TDU_OFFS_TDATA1, TYPE_WORD | DMODE_BIT | M_BIT);
        csr_write(`TDU_OFFS_TDATA2, addr);
        csr_expect("tdata2 locked", `TDU_OFFS_TDATA2, '0);
        csr_write(`TDU_OFFS_TDATA1, '0);
        csr_expect("tdata1 locked", `TDU_OFFS_TDATA1, TYPE_WORD | DMODE_BIT | M_BIT);
        set_dsbl(1'b1);
        csr_write(`TDU_OFFS_TDATA2, addr);
        csr_expect("tdata2 in debug mode", `TDU_OFFS_TDATA2, addr);
        csr_write(`TDU_OFFS_TDATA1, '0);
        csr_expect("tdata1 in debug mode", `TDU_OFFS_TDATA1, TYPE_WORD);
        set_dsbl(1'b0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        csr_req    = 1'b0;
        csr_cmd    = TDU_CMD_NONE;
        csr_addr   = '0;
        csr_wdata  = '0;
        tdu_dsbl   = 1'b0;
        imon_vd    = 1'b0;
        imon_addr  = '0;
        dmon_vd    = 1'b0;
        dmon_load  = 1'b0;
        dmon_store = 1'b0;
        dmon_addr  = '0;
        bp_retire  = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        reset_values();
        set_clear_merge();
        exec_match();
        load_only_match();
        retire_debug_entry();
        dmode_write_lock();
        repeat (2) @(posedge clk);

        assert_fails = tdu_top_inst.asserts_inst.assert_errors;
        $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tdu.f ====
+incdir+include
hdl/tdu_pkg.sv
hdl/tdu_csr_if.sv
hdl/tdu_mcontrol_trig.sv
hdl/tdu_trig_bank.sv
hdl/tdu_top.sv
sim/tdu_asserts.sv
sim/tdu_tb.sv

// ==== Bender.yml ====
package:
  name: tdu

export_include_dirs:
  - include

sources:
  # RTL
  - include_dirs:
      - include
    files:
      - hdl/tdu_pkg.sv
      - hdl/tdu_csr_if.sv
      - hdl/tdu_mcontrol_trig.sv
      - hdl/tdu_trig_bank.sv
      - hdl/tdu_top.sv
  # Testbench and bound assertions
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tdu_asserts.sv
      - sim/tdu_tb.sv
